// File: tb/cfifo_tests.txt
// Each 32-bit hex record is TTOLDDDD: TT test, O operation, L lane, DDDD data
// O: 1 push, 2 stall mask, 3 pop_ready mode, 4 expect pop, 5 expect lane order,
// 6 idle cycles, 7 credits held on lane, 8 wait until every expected pop is seen
01600008 // reset credits settle
01700004
01710004
01720004
01730004
02220002 // stall lane 1
0241A101
0241A102
0211A101
0211A102
02800000
02600004
02710002 // two credits withheld
02200000
02600006
02710004
03300002 // random pop_ready
03401111
03401112
03412221
03433331
03433332
03101111
03133331
03101112
03112221
03133332
03800000
04300000 // pop side held off
04424401
04424402
04124401
04124402
04600006
04300001
04800000
05300000 // all lanes backlogged
05405000
05415100
05425200
05435300
05520000
05530000
05500000
05510000
05125200
05105000
05135300
05115100
05600004
05300001
05800000

// File: flist.f
+incdir+common
common/cfifo_pkg.sv
common/ram_port_if.sv
cfifo/cfifo_ram.sv
cfifo/cfifo_lane.sv
design/push_steer.sv
design/pop_arbiter.sv
design/cfifo_top.sv
tb/cfifo_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the credit FIFO testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module cfifo_tb \
  -Mdir obj_dir -o cfifo_sim > build.log 2>&1 \
  && ./obj_dir/cfifo_sim > sim.log 2>&1 \
  ; cat build.log sim.log 2>/dev/null \
  ; grep -q "TB PASSED" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// File: tb/cfifo_tb.sv
// Self-checking testbench for the multi-lane credit FIFO, replayed from a tests file
`timescale 1ns/1ps
`include "cfifo_cfg.svh"

module cfifo_tb;
  import cfifo_pkg::*;

  // Room for the records of the tests file, unused slots stay zero
  localparam int max_records = 128;

  logic       clk;
  logic       rst_n;
  logic       push_valid;
  lane_id_t   push_lane;
  flit_data_t push_data;
  lane_vec_t  credit_stall;
  lane_vec_t  push_credit;
  logic       pop_valid;
  logic       pop_ready;
  lane_id_t   pop_lane;
  flit_data_t pop_data;

  logic [31:0] records [max_records];
  int          n_records;
  int          n_tests;
  int          errors;
  int          checks;
  int          cycles;
  int          seed;
  // Pop side mode: 0 held low, 1 held high, 2 random
  int          ready_mode;
  lane_vec_t   stall_next;

  // Sender view of the credit loop
  int          credits_held [`CFIFO_LANES];
  int          in_flight [`CFIFO_LANES];

  // Expected pops per lane in push order, plus an optional lane order
  flit_data_t  exp_data_q [`CFIFO_LANES][$];
  lane_id_t    exp_order_q [$];

  // Pop port state seen in the previous cycle while it was stalled
  logic        was_stalled;
  lane_id_t    stalled_lane;
  flit_data_t  stalled_data;

  cfifo_top i_cfifo_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .push_valid   (push_valid),
    .push_lane    (push_lane),
    .push_data    (push_data),
    .credit_stall (credit_stall),
    .push_credit  (push_credit),
    .pop_valid    (pop_valid),
    .pop_ready    (pop_ready),
    .pop_lane     (pop_lane),
    .pop_data     (pop_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ----------------------------------------------------------
  // Checking helpers
  // ----------------------------------------------------------
  task automatic compare_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      $display("FAILED at time %0t: %s is 0x%0h, expected 0x%0h", $time, name, actual,
               expected);
      errors++;
    end
  endtask

  task automatic note_failure(input string msg);
    $display("%s (time %0t)", msg, $time);
    errors++;
  endtask

  function automatic int pending_pops();
    int total;
    total = exp_order_q.size();
    for (int i = 0; i < `CFIFO_LANES; i++) begin
      total += exp_data_q[i].size();
    end
    return total;
  endfunction

  // Outputs are read at the falling edge, half a cycle away from any change
  task automatic sample_outputs();
    lane_id_t   exp_lane;
    flit_data_t exp_data;
    for (int i = 0; i < `CFIFO_LANES; i++) begin
      if (push_credit[i]) begin
        if (credit_stall[i]) begin
          note_failure($sformatf("Lane %0d gave a credit while its stall was high", i));
        end
        // Credits held plus flits in the lane can never pass the depth
        if (credits_held[i] + in_flight[i] >= `CFIFO_DEPTH) begin
          note_failure($sformatf("Lane %0d gave more credits than it has entries", i));
        end
        credits_held[i]++;
      end
    end
    // A stalled pop port must look exactly as it did a cycle ago
    if (was_stalled) begin
      compare_value("pop_valid", pop_valid, 1);
      compare_value("pop_lane", pop_lane, stalled_lane);
      compare_value("pop_data", pop_data, stalled_data);
    end
    // Valid and ready both high here means a transfer at the next rising edge
    if (pop_valid && pop_ready) begin
      if (exp_order_q.size() != 0) begin
        exp_lane = exp_order_q.pop_front();
        compare_value("pop_lane", pop_lane, exp_lane);
      end
      if (exp_data_q[pop_lane].size() == 0) begin
        note_failure($sformatf("Lane %0d popped 0x%0h with no pop expected", pop_lane,
                               pop_data));
      end else begin
        exp_data = exp_data_q[pop_lane].pop_front();
        compare_value("pop_data", pop_data, exp_data);
      end
      in_flight[pop_lane]--;
    end
    was_stalled  = pop_valid && !pop_ready;
    stalled_lane = pop_lane;
    stalled_data = pop_data;
  endtask

  // ----------------------------------------------------------
  // Stimulus helpers
  // ----------------------------------------------------------
  // One clock cycle: drive on the rising edge, sample on the falling edge
  task automatic run_cycle(input logic do_push, input lane_id_t lane, input flit_data_t data);
    logic [31:0] rnd;
    @(posedge clk);
    rnd = $random(seed);
    push_valid   <= do_push;
    push_lane    <= lane;
    push_data    <= data;
    credit_stall <= stall_next;
    if (ready_mode == 2) begin
      pop_ready <= rnd[0];
    end else begin
      pop_ready <= (ready_mode == 1);
    end
    @(negedge clk);
    sample_outputs();
  endtask

  // The sender only pushes on a credit it already holds
  task automatic push_flit(input int lane, input flit_data_t data);
    while (credits_held[lane] == 0) begin
      run_cycle(1'b0, '0, '0);
    end
    credits_held[lane]--;
    in_flight[lane]++;
    run_cycle(1'b1, lane_id_t'(lane), data);
  endtask

  // ----------------------------------------------------------
  // Record replay
  // ----------------------------------------------------------
  initial begin
    logic [31:0] rec;
    int          test_no;
    int          op;
    int          lane;
    int          test_start_errors;
    flit_data_t  data;

    rst_n        = 1'b0;
    push_valid   = 1'b0;
    push_lane    = '0;
    push_data    = '0;
    credit_stall = '0;
    pop_ready    = 1'b0;
    seed         = 55825;
    errors       = 0;
    checks       = 0;
    n_tests      = 0;
    ready_mode   = 1;
    stall_next   = '0;
    was_stalled  = 1'b0;
    stalled_lane = '0;
    stalled_data = '0;
    for (int i = 0; i < `CFIFO_LANES; i++) begin
      credits_held[i] = 0;
      in_flight[i]    = 0;
    end
    for (int r = 0; r < max_records; r++) begin
      records[r] = '0;
    end
    $readmemh("tb/cfifo_tests.txt", records);
    // The records end at the first all-zero word
    n_records = 0;
    while (n_records < max_records && records[n_records] != '0) begin
      n_records++;
    end
    if (n_records == 0) begin
      note_failure("The tests file holds no records");
    end

    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    // First cycle out of reset gives no credit and has nothing to pop
    compare_value("push_credit", push_credit, '0);
    compare_value("pop_valid", pop_valid, 0);

    test_start_errors = 0;
    for (int r = 0; r < n_records; r++) begin
      rec     = records[r];
      test_no = int'(rec[31:24]);
      op      = int'(rec[23:20]);
      lane    = int'(rec[19:16]) % `CFIFO_LANES;
      data    = flit_data_t'(rec[15:0]);
      case (op)
        1: push_flit(lane, data);
        2: stall_next = lane_vec_t'(data);
        3: ready_mode = int'(data);
        4: exp_data_q[lane].push_back(data);
        5: exp_order_q.push_back(lane_id_t'(lane));
        6: repeat (int'(data)) run_cycle(1'b0, '0, '0);
        7: compare_value($sformatf("credits held for lane %0d", lane), credits_held[lane],
                         32'(data));
        8: while (pending_pops() != 0) run_cycle(1'b0, '0, '0);
        default: note_failure($sformatf("Record %0d has unknown operation %0d", r, op));
      endcase
      // A test ends where the next record carries another test number
      if (r == n_records - 1 || records[r + 1][31:24] != rec[31:24]) begin
        $display("Test %0d finished with %0d errors", test_no, errors - test_start_errors);
        test_start_errors = errors;
        n_tests++;
      end
    end

    // A few quiet cycles catch stray pops after the last test
    repeat (4) run_cycle(1'b0, '0, '0);
    $display("%0d tests, %0d checks, %0d errors", n_tests, checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Run limit grows with the number of records
  initial begin
    int limit;
    cycles = 0;
    @(posedge clk);
    limit = 10 * n_records + 200;
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the tests did not finish within %0d clock cycles", limit);
    $display("TB FAILED");
    $finish;
  end

endmodule

// File: design/cfifo_top.sv
// Multi-lane credit FIFO receive buffer with one push port and one pop port
`timescale 1ns/1ps
`include "cfifo_cfg.svh"

module cfifo_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  push_valid,
  input  cfifo_pkg::lane_id_t   push_lane,
  input  cfifo_pkg::flit_data_t push_data,
  input  cfifo_pkg::lane_vec_t  credit_stall,
  output cfifo_pkg::lane_vec_t  push_credit,
  output logic                  pop_valid,
  input  logic                  pop_ready,
  output cfifo_pkg::lane_id_t   pop_lane,
  output cfifo_pkg::flit_data_t pop_data
);
  import cfifo_pkg::*;

  lane_vec_t  lane_push;
  flit_data_t lane_data;
  lane_vec_t  lane_pop_valid;
  lane_vec_t  lane_pop_ready;
  flit_data_t lane_pop_data [`CFIFO_LANES];

  // Registered steering, adds one cycle before the lane write
  push_steer i_push_steer (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_valid (push_valid),
    .push_lane  (push_lane),
    .push_data  (push_data),
    .lane_push  (lane_push),
    .lane_data  (lane_data)
  );

  // ----------------------------------------------------------
  // Lanes, each with its own storage and credit loop
  // ----------------------------------------------------------
  for (genvar i = 0; i < `CFIFO_LANES; i++) begin : g_lane
    cfifo_lane i_cfifo_lane (
      .clk          (clk),
      .rst_n        (rst_n),
      .push         (lane_push[i]),
      .push_data    (lane_data),
      .credit_stall (credit_stall[i]),
      .push_credit  (push_credit[i]),
      .pop_valid    (lane_pop_valid[i]),
      .pop_ready    (lane_pop_ready[i]),
      .pop_data     (lane_pop_data[i])
    );
  end

  // Round-robin drain onto the shared pop port
  pop_arbiter i_pop_arbiter (
    .clk        (clk),
    .rst_n      (rst_n),
    .lane_valid (lane_pop_valid),
    .lane_data  (lane_pop_data),
    .lane_ready (lane_pop_ready),
    .pop_valid  (pop_valid),
    .pop_ready  (pop_ready),
    .pop_lane   (pop_lane),
    .pop_data   (pop_data)
  );

endmodule

// File: design/pop_arbiter.sv
// Round-robin merge of the lane pop requests onto the single pop port
`timescale 1ns/1ps
`include "cfifo_cfg.svh"

module pop_arbiter (
  input  logic                  clk,
  input  logic                  rst_n,
  input  cfifo_pkg::lane_vec_t  lane_valid,
  input  cfifo_pkg::flit_data_t lane_data [`CFIFO_LANES],
  output cfifo_pkg::lane_vec_t  lane_ready,
  output logic                  pop_valid,
  input  logic                  pop_ready,
  output cfifo_pkg::lane_id_t   pop_lane,
  output cfifo_pkg::flit_data_t pop_data
);
  import cfifo_pkg::*;

  localparam lane_id_t last_lane = lane_id_t'(`CFIFO_LANES - 1);

  lane_id_t ptr_q;
  lane_id_t lock_lane_q;
  logic     lock_q;
  lane_id_t pick_lane;
  lane_id_t grant_lane;
  logic     xfer;

  // ----------------------------------------------------------
  // Round-robin pick
  // ----------------------------------------------------------
  // Scan from the priority pointer and take the first valid lane
  always_comb begin
    int  idx;
    logic found;
    found     = 1'b0;
    pick_lane = ptr_q;
    for (int k = 0; k < `CFIFO_LANES; k++) begin
      idx = (int'(ptr_q) + k) % `CFIFO_LANES;
      if (!found && lane_valid[idx]) begin
        found     = 1'b1;
        pick_lane = lane_id_t'(idx);
      end
    end
  end

  // A stalled grant is locked so a newly valid lane cannot steal it
  assign grant_lane = lock_q ? lock_lane_q : pick_lane;
  assign pop_valid  = lane_valid[grant_lane];
  assign pop_lane   = grant_lane;
  assign pop_data   = lane_data[grant_lane];
  assign xfer       = pop_valid && pop_ready;

  always_comb begin
    lane_ready = '0;
    lane_ready[grant_lane] = pop_ready && pop_valid;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ptr_q       <= '0;
      lock_q      <= 1'b0;
      lock_lane_q <= '0;
    end else begin
      lock_q      <= pop_valid && !pop_ready;
      lock_lane_q <= grant_lane;
      // Lowest priority goes to the lane that was just served
      if (xfer) begin
        ptr_q <= (grant_lane == last_lane) ? '0 : grant_lane + 1'b1;
      end
    end
  end

  // The granted lane holds until its flit has been taken
  a_grant_held: assert property (@(posedge clk) disable iff (!rst_n)
    pop_valid && !pop_ready |=> pop_valid && (pop_lane == $past(pop_lane)));

endmodule

// File: design/push_steer.sv
// Push steering stage that registers each flit and routes it to its lane
`timescale 1ns/1ps
`include "cfifo_cfg.svh"

module push_steer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  push_valid,
  input  cfifo_pkg::lane_id_t   push_lane,
  input  cfifo_pkg::flit_data_t push_data,
  output cfifo_pkg::lane_vec_t  lane_push,
  output cfifo_pkg::flit_data_t lane_data
);
  import cfifo_pkg::*;

  lane_vec_t  lane_push_q;
  flit_data_t lane_data_q;
  lane_vec_t  lane_dec;

  // ----------------------------------------------------------
  // Lane decode
  // ----------------------------------------------------------
  // One-hot select of the addressed lane, zero when nothing arrives
  always_comb begin
    lane_dec = '0;
    if (push_valid) begin
      lane_dec[push_lane] = 1'b1;
    end
  end

  // ----------------------------------------------------------
  // Input register
  // ----------------------------------------------------------
  // Strobes are control and clear on reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lane_push_q <= '0;
    end else begin
      lane_push_q <= lane_dec;
    end
  end

  // The payload only matters when a strobe is high
  // Capture it on every push so the RAM write sees a clean flop output
  always_ff @(posedge clk) begin
    if (push_valid) begin
      lane_data_q <= push_data;
    end
  end

  // All lanes share the data bus, only the strobed lane writes it
  assign lane_push = lane_push_q;
  assign lane_data = lane_data_q;

endmodule

// File: cfifo/cfifo_lane.sv
// Single lane FIFO controller with credit return toward the sender
`timescale 1ns/1ps
`include "cfifo_cfg.svh"

module cfifo_lane (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  push,
  input  cfifo_pkg::flit_data_t push_data,
  input  logic                  credit_stall,
  output logic                  push_credit,
  output logic                  pop_valid,
  input  logic                  pop_ready,
  output cfifo_pkg::flit_data_t pop_data
);
  import cfifo_pkg::*;

  // Highest RAM index, the pointers wrap back to zero after it
  localparam ram_addr_t last_addr = ram_addr_t'(`CFIFO_DEPTH - 1);
  // Full depth expressed in count width
  localparam lane_cnt_t depth_cnt = lane_cnt_t'(`CFIFO_DEPTH);

  ram_addr_t wr_ptr_q;
  ram_addr_t rd_ptr_q;
  lane_cnt_t item_cnt_q;
  lane_cnt_t credit_cnt_q;
  logic      credit_live_q;
  logic      pop;

  // Bundle to the flop RAM, this side drives the ctrl modport signals
  ram_port_if ram ();

  // ----------------------------------------------------------
  // Storage path
  // ----------------------------------------------------------
  // Every push goes into the RAM; there is no bypass to the pop side
  assign ram.wr_en   = push;
  assign ram.wr_addr = wr_ptr_q;
  assign ram.wr_data = push_data;
  assign ram.rd_addr = rd_ptr_q;

  // Head of the queue is always on the read port
  assign pop_valid = (item_cnt_q != '0);
  assign pop_data  = ram.rd_data;
  assign pop       = pop_valid && pop_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      item_cnt_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == last_addr) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == last_addr) ? '0 : rd_ptr_q + 1'b1;
      end
      // A push and a pop in the same cycle leave the count unchanged
      item_cnt_q <= item_cnt_q + lane_cnt_t'(push) - lane_cnt_t'(pop);
    end
  end

  // ----------------------------------------------------------
  // Credit loop
  // ----------------------------------------------------------
  // The counter starts full, so the sender gets one credit per entry
  // Credits stay quiet for the first cycle out of reset
  assign push_credit = credit_live_q && (credit_cnt_q != '0) && !credit_stall;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credit_cnt_q  <= depth_cnt;
      credit_live_q <= 1'b0;
    end else begin
      credit_live_q <= 1'b1;
      // A popped entry returns its credit on the same edge that frees it
      credit_cnt_q  <= credit_cnt_q + lane_cnt_t'(pop) - lane_cnt_t'(push_credit);
    end
  end

  cfifo_ram i_cfifo_ram (
    .clk (clk),
    .ram (ram)
  );

  // ----------------------------------------------------------
  // Checks
  // ----------------------------------------------------------
  // A sender that honours its credits can never overfill the lane
  a_no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> (item_cnt_q != depth_cnt));

  // Returned credits plus unspent credits never exceed the storage
  a_credit_bounded: assert property (@(posedge clk) disable iff (!rst_n)
    credit_cnt_q <= depth_cnt);

  // The head entry must not be overwritten while the pop side waits
  a_pop_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
    pop_valid && !pop_ready |=> pop_valid && $stable(pop_data));

endmodule

// File: cfifo/cfifo_ram.sv
// Flop-based storage with one registered write port and one combinational read
`timescale 1ns/1ps
`include "cfifo_cfg.svh"

module cfifo_ram (
  input logic       clk,
  ram_port_if.mem   ram
);
  import cfifo_pkg::*;

  // One payload word per lane entry
  flit_data_t mem_q [`CFIFO_DEPTH];

  // ----------------------------------------------------------
  // Write port
  // ----------------------------------------------------------
  // The written word becomes visible on the read port one cycle later
  always_ff @(posedge clk) begin
    if (ram.wr_en) begin
      mem_q[ram.wr_addr] <= ram.wr_data;
    end
  end

  // ----------------------------------------------------------
  // Read port
  // ----------------------------------------------------------
  // Combinational lookup of the entry at the controller's read pointer
  assign ram.rd_data = mem_q[ram.rd_addr];

  // ----------------------------------------------------------
  // Checks
  // ----------------------------------------------------------
  // The controller's pointer wrap must keep writes inside the array
  a_wr_addr_in_range: assert property (@(posedge clk)
    ram.wr_en |-> (int'(ram.wr_addr) < `CFIFO_DEPTH));

endmodule

// File: common/ram_port_if.sv
// One-write one-read port bundle between a lane controller and its flop RAM
`timescale 1ns/1ps
`include "cfifo_cfg.svh"

interface ram_port_if;
  import cfifo_pkg::*;

  // Write side, sampled by the RAM on the rising clock edge
  logic       wr_en;
  ram_addr_t  wr_addr;
  flit_data_t wr_data;

  // Read side, rd_data follows rd_addr combinationally
  ram_addr_t  rd_addr;
  flit_data_t rd_data;

  // Controller view, everything but the read data is driven from here
  modport ctrl (
    output wr_en, wr_addr, wr_data, rd_addr,
    input  rd_data
  );

  // Storage view, only the read data comes back out
  modport mem (
    input  wr_en, wr_addr, wr_data, rd_addr,
    output rd_data
  );

endinterface

// File: common/cfifo_pkg.sv
// Shared vector types for the multi-lane credit FIFO and its testbench
`include "cfifo_cfg.svh"

package cfifo_pkg;

  // ----------------------------------------------------------
  // Payload and lane addressing
  // ----------------------------------------------------------
  // One flit as it travels from the push port to the pop port
  typedef logic [`CFIFO_WIDTH-1:0] flit_data_t;

  // Lane number as seen on push_lane and pop_lane
  typedef logic [$clog2(`CFIFO_LANES)-1:0] lane_id_t;

  // One bit per lane, used for strobes, credits and stalls
  typedef logic [`CFIFO_LANES-1:0] lane_vec_t;

  // ----------------------------------------------------------
  // Per-lane storage bookkeeping
  // ----------------------------------------------------------
  // Index into a lane's flop RAM
  typedef logic [`CFIFO_ADDR_W-1:0] ram_addr_t;

  // Item count or credit count, wide enough to hold the full depth
  typedef logic [`CFIFO_CNT_W-1:0] lane_cnt_t;

endpackage

// File: common/cfifo_cfg.svh
// Receive buffer configuration: lane count, per-lane depth and flit width
`ifndef CFIFO_CFG_SVH
`define CFIFO_CFG_SVH

// Number of independent lanes behind the single push port
`define CFIFO_LANES 4

// Entries per lane, which is also the credit count each lane hands out
// The depth must be at least 2
`define CFIFO_DEPTH 4

// Payload bits carried by one flit
`define CFIFO_WIDTH 16

// Derived widths for RAM indices and for occupancy or credit counts
`define CFIFO_ADDR_W $clog2(`CFIFO_DEPTH)
`define CFIFO_CNT_W  $clog2(`CFIFO_DEPTH + 1)

`endif
